// ==== compile.f ====
+incdir+verilog
verilog/vsys_pkg.sv
verilog/ar_muldiv.sv
verilog/scale_window.sv
verilog/hps_cmd_decoder.sv
verilog/sync_polarity.sv
verilog/csync_gen.sv
verilog/video_sys_top.sv
bench/video_sys_chk.sv
bench/video_sys_tb.sv

// ==== Makefile ====
# Verilator simulation of the video configuration slice
TOP = video_sys_tb

.PHONY: sim clean

sim:
	verilator --binary -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir

// ==== bench/video_sys_tb.sv ====
`timescale 1ns/10ps
// Testbench for the video configuration slice
// Applies a table of host commands and aspects, then active-low sync waveforms
`include "vsys_cfg.svh"

module video_sys_tb import vsys_pkg::*; ();

	typedef logic [7:0][`VSYS_IO_W-1:0] words_t;

	// Command, bus select, aspect and expected registers and window
	typedef struct packed {
		logic         uio;
		logic [7:0]   code;
		logic [3:0]   nwords;
		words_t       words;
		vsys_aspect_t aspect;
		vsys_timing_t timing;
		vsys_window_t window;
	} row_t;

	localparam int NROWS      = 9;
	localparam int ROW_CYCLES = 2 * 9 + 4 + 3 * `VSYS_WIN_MAX_CYCLES;
	localparam int FRAMES     = 5;
	localparam int LINES      = 12;
	localparam int VS_LINES   = 3;
	localparam int LINE_MAX   = 40;
	localparam int LIMIT      = 10 + NROWS * ROW_CYCLES + FRAMES * LINES * LINE_MAX + 200;

	logic                  clk_sys = 1'b0;
	logic                  resetd;
	logic                  i_io_uio;
	logic                  i_io_strobe;
	logic [`VSYS_IO_W-1:0] i_io_din;
	vsys_aspect_t          i_aspect;
	logic                  i_hs;
	logic                  i_vs;
	logic [`VSYS_IO_W-1:0] o_io_dout;
	vsys_timing_t          o_timing;
	vsys_window_t          o_window;
	logic                  o_hs;
	logic                  o_vs;
	logic                  o_cs;

	row_t         tbl [NROWS];
	vsys_timing_t t_def;
	vsys_timing_t t_800;
	words_t       w_def;
	words_t       w_800;
	int           errors = 0;
	int           checks = 0;
	int           cycles = 0;
	integer       seed = 32'hc73a_d1c8;
	logic         sync_check = 1'b0;
	logic         hs_pulse = 1'b0;
	logic         vs_pulse = 1'b0;
	logic         prev_hs;
	logic         prev_vs;

	video_sys_top i_video_sys_top (.*);

	bind video_sys_top video_sys_chk i_video_sys_chk (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_uio   (i_io_uio),
		.i_io_dout  (o_io_dout),
		.i_window   (o_window),
		.i_md_start (i_scale_window.md_start),
		.i_md_busy  (i_scale_window.md_busy)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [15:0] got,
	                         input logic [15:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic vsys_window_t make_win(input int hmin, input int hmax,
	                                          input int vmin, input int vmax);
		vsys_window_t w;
		w.hmin = vsys_dim_t'(hmin);
		w.hmax = vsys_dim_t'(hmax);
		w.vmin = vsys_dim_t'(vmin);
		w.vmax = vsys_dim_t'(vmax);
		return w;
	endfunction

	function automatic row_t make_row(input logic uio, input logic [7:0] code,
	                                  input logic [3:0] nw, input words_t w, input int arx,
	                                  input int ary, input vsys_timing_t t,
	                                  input vsys_window_t win);
		row_t r;
		r.uio        = uio;
		r.code       = code;
		r.nwords     = nw;
		r.words      = w;
		r.aspect.arx = vsys_dim_t'(arx);
		r.aspect.ary = vsys_dim_t'(ary);
		r.timing     = t;
		r.window     = win;
		return r;
	endfunction

	function automatic words_t one_word(input logic [15:0] v);
		words_t w;
		w    = '0;
		w[0] = v;
		return w;
	endfunction

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	task automatic fill_table();
		t_def = '{width: 12'd1920, hfp: 12'd88, hs: 12'd48, hbp: 12'd148, height: 12'd1080,
		          vfp: 12'd4, vs: 12'd5, vbp: 12'd36, hs_neg: 1'b0, vs_neg: 1'b0};
		t_800 = '{width: 12'd800, hfp: 12'd40, hs: 12'd128, hbp: 12'd88, height: 12'd600,
		          vfp: 12'd1, vs: 12'd4, vbp: 12'd23, hs_neg: 1'b1, vs_neg: 1'b1};
		// Word 0 is rightmost and bit 15 of the HS and VS words is the polarity
		w_800 = {16'd23, 16'h8004, 16'd1, 16'd600, 16'd88, 16'h8080, 16'd40, 16'd800};
		w_def = {16'd36, 16'd5, 16'd4, 16'd1080, 16'd148, 16'd48, 16'd88, 16'd1920};
		// Deselected bus right after reset
		tbl[0] = make_row(1'b0, 8'h20, 4'd8, w_800, 0, 0, t_def, make_win(0, 1919, 0, 1079));
		// Timing code alone leaves the readback set until deselect
		tbl[1] = make_row(1'b1, 8'h20, 4'd0, '0, 4, 3, t_def, make_win(240, 1679, 0, 1079));
		tbl[2] = make_row(1'b1, 8'h27, 4'd1, one_word(16'd720), 16, 9, t_def,
		                  make_win(320, 1599, 180, 899));
		// Freescale with hset 1000
		tbl[3] = make_row(1'b1, 8'h37, 4'd1, one_word(16'h83e8), 16, 9, t_def,
		                  make_win(460, 1459, 180, 899));
		tbl[4] = make_row(1'b1, 8'h37, 4'd1, one_word(16'd0), 0, 0, t_def,
		                  make_win(0, 1919, 180, 899));
		tbl[5] = make_row(1'b1, 8'h27, 4'd1, one_word(16'd0), 0, 0, t_def,
		                  make_win(0, 1919, 0, 1079));
		tbl[6] = make_row(1'b1, 8'h20, 4'd8, w_800, 0, 0, t_800, make_win(0, 799, 0, 599));
		tbl[7] = make_row(1'b1, 8'h00, 4'd0, '0, 16, 9, t_800, make_win(0, 799, 75, 524));
		tbl[8] = make_row(1'b0, 8'h20, 4'd8, w_def, 4, 3, t_800, make_win(0, 799, 0, 599));
	endtask

	task automatic send_word(input logic [`VSYS_IO_W-1:0] w,
	                         input logic [`VSYS_IO_W-1:0] dout_exp);
		@(posedge clk_sys);
		#1;
		i_io_strobe = 1'b1;
		i_io_din    = w;
		@(posedge clk_sys);
		#1;
		i_io_strobe = 1'b0;
		check_val("o_io_dout", o_io_dout, dout_exp);
	endtask

	task automatic run_row(input row_t row);
		int i;
		@(posedge clk_sys);
		#1;
		i_aspect = row.aspect;
		i_io_uio = row.uio;
		send_word({8'h00, row.code},
		          (row.uio && row.code == `VSYS_CMD_TIMING) ? `VSYS_TIMING_ACK : 16'd0);
		for (i = 0; i < int'(row.nwords); i++)
			send_word(row.words[i], 16'd0);
		@(posedge clk_sys);
		#1;
		i_io_uio = 1'b0;
		repeat (3 * `VSYS_WIN_MAX_CYCLES) @(posedge clk_sys);
		check_val("timing.width", 16'(o_timing.width), 16'(row.timing.width));
		check_val("timing.hfp", 16'(o_timing.hfp), 16'(row.timing.hfp));
		check_val("timing.hs", 16'(o_timing.hs), 16'(row.timing.hs));
		check_val("timing.hbp", 16'(o_timing.hbp), 16'(row.timing.hbp));
		check_val("timing.height", 16'(o_timing.height), 16'(row.timing.height));
		check_val("timing.vfp", 16'(o_timing.vfp), 16'(row.timing.vfp));
		check_val("timing.vs", 16'(o_timing.vs), 16'(row.timing.vs));
		check_val("timing.vbp", 16'(o_timing.vbp), 16'(row.timing.vbp));
		check_val("timing.hs_neg", 16'(o_timing.hs_neg), 16'(row.timing.hs_neg));
		check_val("timing.vs_neg", 16'(o_timing.vs_neg), 16'(row.timing.vs_neg));
		check_val("window.hmin", 16'(o_window.hmin), 16'(row.window.hmin));
		check_val("window.hmax", 16'(o_window.hmax), 16'(row.window.hmax));
		check_val("window.vmin", 16'(o_window.vmin), 16'(row.window.vmin));
		check_val("window.vmax", 16'(o_window.vmax), 16'(row.window.vmax));
	endtask

	//////////////////////////////
	// Sync waveforms
	//////////////////////////////
	// Active-low syncs with checking from the third frame on
	task automatic run_sync();
		int f;
		int ln;
		int px;
		int hs_w;
		int line_len;
		hs_w     = 3 + int'($unsigned($random(seed)) % 6);
		line_len = 24 + int'($unsigned($random(seed)) % (LINE_MAX - 23));
		for (f = 0; f < FRAMES; f++) begin
			for (ln = 0; ln < LINES; ln++) begin
				for (px = 0; px < line_len; px++) begin
					@(posedge clk_sys);
					#1;
					hs_pulse = px < hs_w;
					vs_pulse = ln < VS_LINES;
					i_hs     = !hs_pulse;
					i_vs     = !vs_pulse;
					if (f == 2 && ln == 0 && px == 0)
						sync_check = 1'b1;
				end
			end
		end
		sync_check = 1'b0;
	endtask

	// Mid-cycle check of active-high syncs and csync tracking hsync
	always @(negedge clk_sys) begin
		if (sync_check) begin
			check_val("o_hs", 16'(o_hs), 16'(hs_pulse));
			check_val("o_vs", 16'(o_vs), 16'(vs_pulse));
			if (!prev_vs)
				check_val("o_cs", 16'(o_cs), 16'(prev_hs));
		end
		prev_hs = o_hs;
		prev_vs = o_vs;
	end

	initial begin
		resetd      = 1'b1;
		i_io_uio    = 1'b0;
		i_io_strobe = 1'b0;
		i_io_din    = '0;
		i_aspect    = '0;
		i_hs        = 1'b1;
		i_vs        = 1'b1;
		fill_table();
		repeat (10) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		for (int r = 0; r < NROWS; r++)
			run_row(tbl[r]);
		run_sync();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/video_sys_chk.sv ====
`timescale 1ns/10ps
// Concurrent checks on the video config top, attached with bind
// Muldiv handshake, window ordering and the readback clear on deselect
`include "vsys_cfg.svh"

module video_sys_chk import vsys_pkg::*; (
	input logic                  clk_sys,
	input logic                  resetd,
	input logic                  i_io_uio,
	input logic [`VSYS_IO_W-1:0] i_io_dout,
	input vsys_window_t          i_window,
	input logic                  i_md_start,
	input logic                  i_md_busy
);

	// Start only while the divider is idle
	a_start_idle: assert property (@(posedge clk_sys) disable iff (resetd)
		i_md_start |-> !i_md_busy)
		else $error("muldiv start issued while busy");

	a_win_order: assert property (@(posedge clk_sys) disable iff (resetd)
		i_window.hmin <= i_window.hmax)
		else $error("window hmin above hmax");

	// Deselecting the bus clears the readback register
	a_dout_idle: assert property (@(posedge clk_sys) disable iff (resetd)
		!i_io_uio |=> i_io_dout == '0)
		else $error("readback word not cleared after bus deselect");

endmodule

// ==== verilog/video_sys_top.sv ====
`timescale 1ns/10ps
// Video configuration slice: host decoder, window calculator and sync fixing
// Everything runs on clk_sys with the synchronous reset resetd
`include "vsys_cfg.svh"

module video_sys_top import vsys_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_uio,
	input  logic                  i_io_strobe,
	input  logic [`VSYS_IO_W-1:0] i_io_din,
	input  vsys_aspect_t          i_aspect,
	input  logic                  i_hs,
	input  logic                  i_vs,
	output logic [`VSYS_IO_W-1:0] o_io_dout,
	output vsys_timing_t          o_timing,
	output vsys_window_t          o_window,
	output logic                  o_hs,
	output logic                  o_vs,
	output logic                  o_cs
);

	vsys_scale_t scale;

	hps_cmd_decoder i_hps_cmd_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_timing    (o_timing),
		.o_scale     (scale),
		.o_io_dout   (o_io_dout)
	);

	scale_window i_scale_window (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_timing (o_timing),
		.i_scale  (scale),
		.i_aspect (i_aspect),
		.o_window (o_window)
	);

	// Core syncs to active-high
	sync_polarity i_sync_pol_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity i_sync_pol_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

	csync_gen i_csync_gen (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (o_hs),
		.i_vs    (o_vs),
		.o_cs    (o_cs)
	);

endmodule

// ==== verilog/csync_gen.sv ====
`timescale 1ns/10ps
// Composite sync from active-high hsync and vsync
// During vsync the hsync pulses are inverted and shifted by one line
`include "vsys_cfg.svh"

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_cs
);

	logic                        hs_d;
	logic                        cs_hs;
	logic                        cs_vs;
	logic [`VSYS_SYNC_CNT_W-1:0] h_cnt;
	logic [`VSYS_SYNC_CNT_W-1:0] line_len;
	logic [`VSYS_SYNC_CNT_W-1:0] hs_len;

	assign o_cs = cs_hs ^ cs_vs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hs_d <= i_hs;
			// Measure hsync width and the rest of the line
			if (hs_d != i_hs) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end else if (~&h_cnt) begin
				h_cnt <= h_cnt + 1'b1;
			end

			if (!i_vs)
				cs_hs <= i_hs;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;

			cs_vs <= i_vs;
		end
	end

endmodule

// ==== verilog/sync_polarity.sv ====
`timescale 1ns/10ps
// Turns a sync of either polarity into an active-high sync
// Compares the high and low phase lengths, the shorter one is the pulse
`include "vsys_cfg.svh"

module sync_polarity (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                        s1;
	logic                        s2;
	logic                        pol;
	logic [`VSYS_SYNC_CNT_W-1:0] cnt;
	logic [`VSYS_SYNC_CNT_W-1:0] high_len;
	logic [`VSYS_SYNC_CNT_W-1:0] low_len;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			pol      <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;
			// Rising edge closes a low phase, falling edge a high one
			if (s1 && !s2)
				low_len <= cnt;
			if (!s1 && s2)
				high_len <= cnt;
			pol <= high_len > low_len;
		end
	end

endmodule

// ==== verilog/hps_cmd_decoder.sv ====
`timescale 1ns/10ps
// Host command decoder for the strobed 16-bit bus
// First word of a command is the code, later words are its parameters
// Loads the output timing and scale registers, drives the readback word
`include "vsys_cfg.svh"

module hps_cmd_decoder import vsys_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  i_io_uio,
	input  logic                  i_io_strobe,
	input  logic [`VSYS_IO_W-1:0] i_io_din,
	output vsys_timing_t          o_timing,
	output vsys_scale_t           o_scale,
	output logic [`VSYS_IO_W-1:0] o_io_dout
);

	localparam vsys_timing_t TIMING_DEF = '{
		width:  `VSYS_DEF_WIDTH,
		hfp:    `VSYS_DEF_HFP,
		hs:     `VSYS_DEF_HS,
		hbp:    `VSYS_DEF_HBP,
		height: `VSYS_DEF_HEIGHT,
		vfp:    `VSYS_DEF_VFP,
		vs:     `VSYS_DEF_VS,
		vbp:    `VSYS_DEF_VBP,
		hs_neg: 1'b0,
		vs_neg: 1'b0
	};

	logic                  has_cmd;
	logic [7:0]            cmd;
	logic [3:0]            cnt;
	logic [`VSYS_IO_W-1:0] dout_q;
	vsys_dim_t             din_dim;
	logic                  din_flag;

	assign din_dim  = i_io_din[`VSYS_DIM_W-1:0];
	assign din_flag = i_io_din[`VSYS_IO_W-1];

	// Readback only visible while the bus is selected
	assign o_io_dout = i_io_uio ? dout_q : '0;

	//////////////////////////////
	// Command sequencing
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			cmd      <= '0;
			cnt      <= '0;
			dout_q   <= '0;
			o_timing <= TIMING_DEF;
			o_scale  <= '0;
		end else if (!i_io_uio) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			dout_q  <= '0;
		end else if (i_io_strobe) begin
			dout_q <= '0;
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= i_io_din[7:0];
				cnt     <= '0;
				if (i_io_din[7:0] == `VSYS_CMD_TIMING)
					dout_q <= `VSYS_TIMING_ACK;
			end else begin
				// Word index saturates, long commands just run out
				if (cnt != 4'hf)
					cnt <= cnt + 4'd1;
				case (cmd)
					`VSYS_CMD_TIMING: begin
						case (cnt)
							4'd0: o_timing.width <= din_dim;
							4'd1: o_timing.hfp   <= din_dim;
							4'd2: begin
								o_timing.hs     <= din_dim;
								o_timing.hs_neg <= din_flag;
							end
							4'd3: o_timing.hbp    <= din_dim;
							4'd4: o_timing.height <= din_dim;
							4'd5: o_timing.vfp    <= din_dim;
							4'd6: begin
								o_timing.vs     <= din_dim;
								o_timing.vs_neg <= din_flag;
							end
							4'd7: o_timing.vbp <= din_dim;
							default: ;
						endcase
					end
					`VSYS_CMD_VSET: begin
						if (cnt == 4'd0)
							o_scale.vset <= din_dim;
					end
					`VSYS_CMD_HSET: begin
						if (cnt == 4'd0) begin
							o_scale.hset      <= din_dim;
							o_scale.freescale <= din_flag;
						end
					end
					// Other codes are not ours
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== verilog/scale_window.sv ====
`timescale 1ns/10ps
// Centred output window from the core aspect ratio and the scale limits
// Runs passes back to back, o_window updates at the end of each pass
`include "vsys_cfg.svh"

module scale_window import vsys_pkg::*; (
	input  logic         clk_sys,
	input  logic         resetd,
	input  vsys_timing_t i_timing,
	input  vsys_scale_t  i_scale,
	input  vsys_aspect_t i_aspect,
	output vsys_window_t o_window
);

	typedef enum logic [2:0] {
		S_LIMIT,
		S_CHOOSE,
		S_W_WAIT,
		S_H_WAIT,
		S_CLAMP,
		S_WIN
	} state_t;

	state_t       state;
	vsys_aspect_t ar_q;
	vsys_dim_t    height_lim;
	vsys_dim_t    width_lim;
	vsys_dim_t    wcalc;
	vsys_dim_t    hcalc;
	vsys_dim_t    videow;
	vsys_dim_t    videoh;
	vsys_dim_t    hmin_c;
	vsys_dim_t    vmin_c;

	logic         md_start;
	logic         md_busy;
	vsys_dim_t    md_mul1;
	vsys_dim_t    md_mul2;
	vsys_dim_t    md_div;
	vsys_dim_t    md_result;

	ar_muldiv i_ar_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

	assign hmin_c = (i_timing.width - videow) >> 1;
	assign vmin_c = (i_timing.height - videoh) >> 1;

	//////////////////////////////
	// Window pass
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= S_LIMIT;
			md_start <= 1'b0;
			o_window <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				S_LIMIT: begin
					height_lim <= (i_scale.vset != '0 && i_scale.vset < i_timing.height) ?
					              i_scale.vset : i_timing.height;
					width_lim  <= (i_scale.hset != '0 && i_scale.hset < i_timing.width) ?
					              i_scale.hset : i_timing.width;
					ar_q       <= i_aspect;
					state      <= S_CHOOSE;
				end
				S_CHOOSE: begin
					if (i_scale.freescale || ar_q.arx == '0 || ar_q.ary == '0) begin
						wcalc <= width_lim;
						hcalc <= height_lim;
						state <= S_CLAMP;
					end else begin
						// Width from the height limit first
						md_mul1  <= height_lim;
						md_mul2  <= ar_q.arx;
						md_div   <= ar_q.ary;
						md_start <= 1'b1;
						state    <= S_W_WAIT;
					end
				end
				S_W_WAIT: begin
					if (!md_start && !md_busy) begin
						wcalc    <= md_result;
						md_mul1  <= width_lim;
						md_mul2  <= ar_q.ary;
						md_div   <= ar_q.arx;
						md_start <= 1'b1;
						state    <= S_H_WAIT;
					end
				end
				S_H_WAIT: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_result;
						state <= S_CLAMP;
					end
				end
				S_CLAMP: begin
					// Degenerate zero size kept to one pixel
					if (wcalc > width_lim)
						videow <= width_lim;
					else if (wcalc == '0)
						videow <= vsys_dim_t'(1);
					else
						videow <= wcalc;
					if (hcalc > height_lim)
						videoh <= height_lim;
					else if (hcalc == '0)
						videoh <= vsys_dim_t'(1);
					else
						videoh <= hcalc;
					state <= S_WIN;
				end
				S_WIN: begin
					o_window.hmin <= hmin_c;
					o_window.hmax <= hmin_c + videow - 1'b1;
					o_window.vmin <= vmin_c;
					o_window.vmax <= vmin_c + videoh - 1'b1;
					state         <= S_LIMIT;
				end
				default: state <= S_LIMIT;
			endcase
		end
	end

endmodule

// ==== verilog/ar_muldiv.sv ====
`timescale 1ns/10ps
// Sequential unsigned mul1 * mul2 / div for the aspect arithmetic
// Pulse i_start while idle, result is valid once o_busy falls again
// Quotient above the field range or a zero divisor returns all ones
`include "vsys_cfg.svh"

module ar_muldiv import vsys_pkg::*; (
	input  logic      clk_sys,
	input  logic      resetd,
	input  logic      i_start,
	input  vsys_dim_t i_mul1,
	input  vsys_dim_t i_mul2,
	input  vsys_dim_t i_div,
	output logic      o_busy,
	output vsys_dim_t o_result
);

	localparam int W = `VSYS_DIM_W;

	logic [$clog2(W+1)-1:0] step;
	vsys_dim_t              mul1_q;
	vsys_dim_t              mul2_q;
	vsys_dim_t              div_q;
	vsys_dim_t              rem;
	vsys_dim_t              quo;
	logic                   ovf;
	logic [2*W-1:0]         prod;
	logic [W:0]             trial;

	assign prod  = mul1_q * mul2_q;
	// Next partial remainder with one dividend bit shifted in
	assign trial = {rem, quo[W-1]} - {1'b0, div_q};

	assign o_result = ovf ? '1 : quo;

	// Step 0 forms the product, steps 1 to W divide
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (o_busy) begin
			if (step == W[$clog2(W+1)-1:0]) begin
				o_busy <= 1'b0;
				step   <= '0;
			end else begin
				step <= step + 1'b1;
			end
		end else if (i_start) begin
			o_busy <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!o_busy && i_start) begin
			mul1_q <= i_mul1;
			mul2_q <= i_mul2;
			div_q  <= i_div;
		end else if (o_busy) begin
			if (step == '0) begin
				// Upper half not below divisor means quotient overflow
				rem <= prod[2*W-1:W];
				quo <= prod[W-1:0];
				ovf <= prod[2*W-1:W] >= div_q;
			end else if (!trial[W]) begin
				rem <= trial[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				rem <= {rem[W-2:0], quo[W-1]};
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

endmodule

// ==== verilog/vsys_pkg.sv ====
// Struct types shared by the video config RTL and its testbench
// Modules take them through a wildcard import in the module header
`include "vsys_cfg.svh"

package vsys_pkg;

	// One dimension, count or aspect value
	typedef logic [`VSYS_DIM_W-1:0] vsys_dim_t;

	// Output mode as loaded by the timing command
	typedef struct packed {
		vsys_dim_t width;
		vsys_dim_t hfp;
		vsys_dim_t hs;
		vsys_dim_t hbp;
		vsys_dim_t height;
		vsys_dim_t vfp;
		vsys_dim_t vs;
		vsys_dim_t vbp;
		logic      hs_neg;
		logic      vs_neg;
	} vsys_timing_t;

	// Height and width limits, freescale ignores the aspect
	typedef struct packed {
		vsys_dim_t vset;
		vsys_dim_t hset;
		logic      freescale;
	} vsys_scale_t;

	typedef struct packed {
		vsys_dim_t arx;
		vsys_dim_t ary;
	} vsys_aspect_t;

	// Centred output window, inclusive bounds
	typedef struct packed {
		vsys_dim_t hmin;
		vsys_dim_t hmax;
		vsys_dim_t vmin;
		vsys_dim_t vmax;
	} vsys_window_t;

endpackage

// ==== verilog/vsys_cfg.svh ====
// Widths, host command codes and reset timing for the video config block
// Include in any file that needs a width, code or default value
`ifndef VSYS_CFG_SVH
`define VSYS_CFG_SVH

// Field and bus widths
`define VSYS_DIM_W          12
`define VSYS_IO_W           16
`define VSYS_SYNC_CNT_W     16

// Host command codes and readback
`define VSYS_CMD_TIMING     8'h20
`define VSYS_CMD_VSET       8'h27
`define VSYS_CMD_HSET       8'h37
`define VSYS_TIMING_ACK     16'd3

// Reset mode is 1920x1080 CEA
`define VSYS_DEF_WIDTH      12'd1920
`define VSYS_DEF_HFP        12'd88
`define VSYS_DEF_HS         12'd48
`define VSYS_DEF_HBP        12'd148
`define VSYS_DEF_HEIGHT     12'd1080
`define VSYS_DEF_VFP        12'd4
`define VSYS_DEF_VS         12'd5
`define VSYS_DEF_VBP        12'd36

// Worst case length of one window pass in clk_sys cycles
`define VSYS_WIN_MAX_CYCLES 64

`endif
